//--- rtl/player_pkg.sv
`default_nettype none

package player_pkg;

  // ============================================================
  // Key codes from the keyboard path, plain ASCII
  // ============================================================
  typedef logic [7:0] key_t;

  localparam key_t key_play     = 8'h45;
  localparam key_t key_pause    = 8'h44;
  localparam key_t key_forward  = 8'h46;
  localparam key_t key_backward = 8'h42;
  localparam key_t key_restart  = 8'h52;

  // Playback mode as seen by the fetcher
  typedef struct packed {
    logic playing;
    logic backward;
  } play_state_t;

  // ============================================================
  // Sample tick period, in system clocks
  // ============================================================
  typedef logic [15:0] period_t;

  // About 22 kHz from the 50 MHz clock
  localparam period_t default_period = 16'd2272;
  localparam period_t period_step    = 16'd64;
  localparam period_t min_period     = 16'd256;
  localparam period_t max_period     = 16'd8192;

endpackage

`default_nettype wire

//--- rtl/flash_pkg.sv
`default_nettype none

package flash_pkg;

  // Word address into the song flash
  typedef logic [22:0] flash_addr_t;

  localparam flash_addr_t last_flash_addr = 23'h7FFFF;

  // One flash word holds two 16-bit halves
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } flash_halves_t;

  typedef union packed {
    logic [31:0]   raw;
    flash_halves_t half;
  } flash_word_u;

  typedef logic signed [7:0] sample_t;

  // Read bus, master side
  typedef struct packed {
    logic        read;
    flash_addr_t address;
    logic [3:0]  byteenable;
  } flash_req_t;

  // Read bus, slave side
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    logic [31:0] readdata;
  } flash_rsp_t;

endpackage

`default_nettype wire

//--- rtl/speed_control.sv
`timescale 1ns/10ps
`default_nettype none

module speed_control import player_pkg::*; (
  input  logic    CLK_50M,
  input  logic    rst,
  input  logic    speed_up,
  input  logic    speed_down,
  input  logic    speed_reset,
  output period_t tick_period
);

  period_t faster;
  period_t slower;

  // Clamped neighbours of the current period
  always_comb
  begin
    if (tick_period < min_period + period_step)
      faster = min_period;
    else
      faster = tick_period - period_step;

    if (tick_period > max_period - period_step)
      slower = max_period;
    else
      slower = tick_period + period_step;
  end

  // Speed reset wins, then up, then down
  always_ff @(posedge CLK_50M)
  begin
    if (rst || speed_reset)
      tick_period <= default_period;
    else if (speed_up)
      tick_period <= faster;
    else if (speed_down)
      tick_period <= slower;
  end

endmodule

`default_nettype wire

//--- rtl/sample_tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module sample_tick_gen import player_pkg::*; (
  input  logic    CLK_50M,
  input  logic    rst,
  input  period_t tick_period,
  output logic    sample_tick
);

  period_t count;

  // Counts period-1 down to 0, so ticks are tick_period clocks apart
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count       <= '0;
      sample_tick <= 1'b0;
    end
    else if (count == '0)
    begin
      // Reload picks up a new period here
      count       <= tick_period - period_t'(1);
      sample_tick <= 1'b1;
    end
    else
    begin
      count       <= count - period_t'(1);
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/player_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module player_ctrl import player_pkg::*; (
  input  logic        CLK_50M,
  input  logic        rst,
  input  key_t        key,
  output play_state_t play,
  output logic        restart
);

  key_t prev_key;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      play     <= '0;
      prev_key <= '0;
      restart  <= 1'b0;
    end
    else
    begin
      prev_key <= key;
      // Only the first cycle of a held R
      restart  <= (key == key_restart) && (prev_key != key_restart);

      case (key)
        key_play:
          play.playing <= 1'b1;
        key_pause:
          play.playing <= 1'b0;
        key_forward:
          play.backward <= 1'b0;
        key_backward:
          play.backward <= 1'b1;
        default:
        begin
          // Anything else leaves the mode alone
          play <= play;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/sample_fetcher.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fetcher import player_pkg::*; import flash_pkg::*; (
  input  logic        CLK_50M,
  input  logic        rst,
  input  play_state_t play,
  input  logic        restart,
  input  logic        sample_tick,
  input  flash_rsp_t  flash_rsp,
  output flash_req_t  flash_req,
  output sample_t     audio_sample,
  output logic        sample_strobe
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait
  } fetch_state_t;

  fetch_state_t state;
  flash_addr_t  addr;
  flash_addr_t  rd_addr;
  flash_word_u  word;
  logic         held;
  logic         second_half;
  // Read in flight when a restart came, its data is stale
  logic         drop_data;

  // Sample is the upper byte of the chosen half
  function automatic sample_t upper_byte(flash_word_u w, logic take_hi);
    sample_t s;
    if (take_hi)
      s = w.half.hi[15:8];
    else
      s = w.half.lo[15:8];
    return s;
  endfunction

  // Next word address, wrapping at both ends of the song
  function automatic flash_addr_t step_addr(flash_addr_t a, logic backward);
    flash_addr_t n;
    if (backward)
      n = (a == '0) ? last_flash_addr : a - flash_addr_t'(1);
    else
      n = (a == last_flash_addr) ? '0 : a + flash_addr_t'(1);
    return n;
  endfunction

  assign flash_req.read       = (state == st_request);
  assign flash_req.address    = rd_addr;
  assign flash_req.byteenable = 4'hF;

  // ============================================================
  // Read FSM and sample selection
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    sample_strobe <= 1'b0;
    if (rst)
    begin
      state       <= st_idle;
      addr        <= '0;
      rd_addr     <= '0;
      held        <= 1'b0;
      second_half <= 1'b0;
      drop_data   <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
          if (sample_tick && play.playing && !restart)
          begin
            if (held)
            begin
              // Forward plays lo first, backward plays hi first
              audio_sample  <= upper_byte(word, play.backward ^ second_half);
              sample_strobe <= 1'b1;
              if (second_half)
              begin
                addr        <= step_addr(addr, play.backward);
                held        <= 1'b0;
                second_half <= 1'b0;
              end
              else
                second_half <= 1'b1;
            end
            else
            begin
              rd_addr <= addr;
              state   <= st_request;
            end
          end
        st_request:
          if (!flash_rsp.waitrequest)
            state <= st_wait;
        st_wait:
          if (flash_rsp.readdatavalid)
          begin
            state     <= st_idle;
            drop_data <= 1'b0;
            if (!drop_data && !restart)
            begin
              word.raw <= flash_rsp.readdata;
              held     <= 1'b1;
              // Paused meanwhile, keep the word and play it on a later tick
              if (play.playing)
              begin
                audio_sample  <= upper_byte(flash_word_u'(flash_rsp.readdata),
                                            play.backward);
                sample_strobe <= 1'b1;
                second_half   <= 1'b1;
              end
              else
                second_half <= 1'b0;
            end
          end
        default:
          state <= st_idle;
      endcase

      if (restart)
      begin
        addr        <= play.backward ? last_flash_addr : '0;
        held        <= 1'b0;
        second_half <= 1'b0;
        drop_data   <= (state == st_request) ||
                       ((state == st_wait) && !flash_rsp.readdatavalid);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/simple_ipod.sv
`timescale 1ns/10ps
`default_nettype none

module simple_ipod import player_pkg::*; import flash_pkg::*; (
  input  logic       CLK_50M,
  input  logic       rst,
  input  key_t       key,
  input  logic       speed_up,
  input  logic       speed_down,
  input  logic       speed_reset,
  input  flash_rsp_t flash_rsp,
  output flash_req_t flash_req,
  output sample_t    audio_sample,
  output logic       sample_strobe,
  output period_t    tick_period
);

  play_state_t play;
  logic        restart;
  logic        sample_tick;

  // Key codes to play mode
  player_ctrl ctrl0 (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .key     (key),
    .play    (play),
    .restart (restart)
  );

  speed_control speed0 (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .tick_period (tick_period)
  );

  sample_tick_gen tick0 (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .tick_period (tick_period),
    .sample_tick (sample_tick)
  );

  // Flash reads and sample output
  sample_fetcher fetch0 (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .play          (play),
    .restart       (restart),
    .sample_tick   (sample_tick),
    .flash_rsp     (flash_rsp),
    .flash_req     (flash_req),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe)
  );

endmodule

`default_nettype wire

//--- tests/simple_ipod_properties.sv
`timescale 1ns/10ps
`default_nettype none

module simple_ipod_properties import player_pkg::*; import flash_pkg::*; (
  input logic        CLK_50M,
  input logic        rst,
  input play_state_t play,
  input logic        sample_strobe,
  input flash_req_t  flash_req,
  input flash_rsp_t  flash_rsp
);

  int unsigned fail_count = 0;
  // Read accepted and its data not back yet
  logic        outstanding;

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      outstanding <= 1'b0;
    else if (flash_req.read && !flash_rsp.waitrequest)
      outstanding <= 1'b1;
    else if (flash_rsp.readdatavalid)
      outstanding <= 1'b0;
  end

  hold_during_wait: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
  else
  begin
    fail_count++;
    $error("Flash read or address changed while waitrequest was high");
  end

  single_read: assert property (@(posedge CLK_50M) disable iff (rst)
    outstanding |-> !flash_req.read)
  else
  begin
    fail_count++;
    $error("A second flash read started while one was outstanding");
  end

  data_expected: assert property (@(posedge CLK_50M) disable iff (rst)
    flash_rsp.readdatavalid |-> outstanding)
  else
  begin
    fail_count++;
    $error("Flash data returned with no read outstanding");
  end

  // Playing when the strobe was issued
  strobe_playing: assert property (@(posedge CLK_50M) disable iff (rst)
    sample_strobe |-> $past(play.playing))
  else
  begin
    fail_count++;
    $error("Sample strobe while playback was paused");
  end

endmodule

bind sample_fetcher simple_ipod_properties props0 (
  .CLK_50M       (CLK_50M),
  .rst           (rst),
  .play          (play),
  .sample_strobe (sample_strobe),
  .flash_req     (flash_req),
  .flash_rsp     (flash_rsp)
);

`default_nettype wire

//--- tests/tb_simple_ipod.sv
`timescale 1ns/10ps
`default_nettype none

module tb_simple_ipod import player_pkg::*; import flash_pkg::*; ();

  localparam key_t key_none = 8'h00;
  // 40 samples at the slowest tick rate, plus margin
  localparam int cycle_limit = 40 * int'(max_period) + 5000;

  logic        CLK_50M;
  logic        rst;
  key_t        key;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  flash_rsp_t  flash_rsp;
  flash_req_t  flash_req;
  sample_t     audio_sample;
  logic        sample_strobe;
  period_t     tick_period;

  integer      seed = 32'hcd75;
  int          errors = 0;
  int          sample_count = 0;
  int          cycles = 0;
  string       test_name = "reset";
  logic        quiet = 1'b0;
  period_t     exp_period;
  // Expected playback position, kept from the player rules
  flash_addr_t exp_addr = '0;
  logic        exp_second = 1'b0;
  logic        exp_backward = 1'b0;
  logic        word_read = 1'b0;

  simple_ipod dut0 (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .key           (key),
    .speed_up      (speed_up),
    .speed_down    (speed_down),
    .speed_reset   (speed_reset),
    .flash_rsp     (flash_rsp),
    .flash_req     (flash_req),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe),
    .tick_period   (tick_period)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Upper bytes carry 2a and 2a+1, lower bytes the rest of the address
  function automatic logic [31:0] flash_word(flash_addr_t a);
    return {a[6:0], 1'b1, a[22:15], a[6:0], 1'b0, a[14:7]};
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("[FAIL] %s: %s expected %0h, got %0h", test_name, what, expected, actual);
  endtask

  // ============================================================
  // Flash model with random wait and data latency
  // ============================================================
  initial
  begin : flash_model
    int unsigned wait_cycles;
    int unsigned data_latency;
    flash_addr_t req_addr;
    flash_rsp = '0;
    forever
    begin
      @(posedge CLK_50M);
      #2;
      if (flash_req.read)
      begin
        wait_cycles  = $unsigned($random(seed)) % 4;
        data_latency = $unsigned($random(seed)) % 4 + 1;
        req_addr     = flash_req.address;
        flash_rsp.waitrequest = (wait_cycles != 0);
        repeat (wait_cycles)
        begin
          @(posedge CLK_50M);
          #2;
        end
        flash_rsp.waitrequest = 1'b0;
        repeat (data_latency)
        begin
          @(posedge CLK_50M);
          #2;
        end
        flash_rsp.readdatavalid = 1'b1;
        flash_rsp.readdata      = flash_word(req_addr);
        @(posedge CLK_50M);
        #2;
        flash_rsp.readdatavalid = 1'b0;
      end
    end
  end

  // ============================================================
  // Checking
  // ============================================================
  always @(posedge CLK_50M)
  begin
    logic       take_hi;
    logic [7:0] exp_sample;
    if (!rst && sample_strobe)
    begin
      // Forward plays lo then hi, backward hi then lo
      take_hi    = exp_backward ^ exp_second;
      exp_sample = {exp_addr[6:0], take_hi};
      assert (audio_sample == exp_sample) else
        report_mismatch("sample", {24'h0, exp_sample}, {24'h0, audio_sample});
      if (exp_second)
      begin
        if (exp_backward)
          exp_addr = (exp_addr == '0) ? last_flash_addr : exp_addr - 23'd1;
        else
          exp_addr = (exp_addr == last_flash_addr) ? '0 : exp_addr + 23'd1;
        word_read = 1'b0;
      end
      exp_second   = !exp_second;
      sample_count = sample_count + 1;
    end
    if (!rst && flash_req.read && !flash_rsp.waitrequest)
    begin
      assert (flash_req.address == exp_addr) else
        report_mismatch("read address", {9'h0, exp_addr}, {9'h0, flash_req.address});
      assert (!word_read && !exp_second) else
      begin
        errors++;
        $display("A flash word was read again before both of its samples had played");
      end
      word_read = 1'b1;
    end
  end

  quiet_window: assert property (@(posedge CLK_50M) quiet |-> !flash_req.read && !sample_strobe)
  else
  begin
    errors++;
    $display("The DUT read the flash or strobed a sample during the %s window", test_name);
  end

  byte_enables: assert property (@(posedge CLK_50M)
    flash_req.read |-> flash_req.byteenable == 4'hF)
  else
  begin
    errors++;
    $display("A flash read was issued without all byte enables set");
  end

  initial
  begin : watchdog
    while (cycles < cycle_limit)
    begin
      @(posedge CLK_50M);
      cycles++;
    end
    $display("Timeout after %0d cycles while waiting for samples in %s", cycles, test_name);
    $display("Test failed");
    $finish;
  end

  // ============================================================
  // Stimulus
  // ============================================================
  task automatic drive_key(input key_t k);
    key = k;
    @(posedge CLK_50M);
    #2;
    key = key_none;
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic restore);
    int next;
    speed_up    = up;
    speed_down  = down;
    speed_reset = restore;
    @(posedge CLK_50M);
    #2;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    next = int'(exp_period);
    if (restore)
      next = int'(default_period);
    else if (up)
      next = next - int'(period_step);
    else if (down)
      next = next + int'(period_step);
    if (next < int'(min_period))
      next = int'(min_period);
    if (next > int'(max_period))
      next = int'(max_period);
    exp_period = period_t'(next);
    assert (tick_period == exp_period) else
      report_mismatch("tick_period", {16'h0, exp_period}, {16'h0, tick_period});
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = sample_count + n;
    while (sample_count < target)
    begin
      @(posedge CLK_50M);
      #2;
    end
  endtask

  initial
  begin : stimulus
    rst         = 1'b1;
    key         = key_none;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    exp_period  = default_period;
    repeat (4) @(posedge CLK_50M);
    #2;
    rst   = 1'b0;
    quiet = 1'b1;
    repeat (100) @(posedge CLK_50M);
    #2;
    quiet = 1'b0;
    assert (tick_period == default_period) else
      report_mismatch("tick_period", {16'h0, default_period}, {16'h0, tick_period});

    test_name = "speed";
    repeat (34) pulse_speed(1'b1, 1'b0, 1'b0);
    assert (tick_period == min_period) else
      report_mismatch("clamped tick_period", {16'h0, min_period}, {16'h0, tick_period});
    repeat (3) pulse_speed(1'b0, 1'b1, 1'b0);
    pulse_speed(1'b0, 1'b0, 1'b1);

    // Odd count, so the pause falls inside a word
    test_name = "forward";
    drive_key(key_play);
    wait_samples(7);

    test_name = "pause";
    drive_key(key_pause);
    quiet = 1'b1;
    repeat (3 * int'(exp_period)) @(posedge CLK_50M);
    #2;
    quiet = 1'b0;
    drive_key(key_play);
    wait_samples(4);

    test_name = "restart";
    drive_key(key_restart);
    exp_addr   = '0;
    exp_second = 1'b0;
    word_read  = 1'b0;
    wait_samples(2);

    // From word 1 down through 0 and on to the last word
    test_name = "backward";
    drive_key(key_backward);
    exp_backward = 1'b1;
    wait_samples(8);

    $display("Errors: %0d in testbench checks, %0d in bus properties, %0d samples seen",
             errors, dut0.fetch0.props0.fail_count, sample_count);
    if (errors == 0 && dut0.fetch0.props0.fail_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
rtl/player_pkg.sv
rtl/flash_pkg.sv
rtl/speed_control.sv
rtl/sample_tick_gen.sv
rtl/player_ctrl.sv
rtl/sample_fetcher.sv
rtl/simple_ipod.sv
tests/simple_ipod_properties.sv
tests/tb_simple_ipod.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_simple_ipod
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Test passed
VFLAGS     := --binary --timing --assert --timescale 1ns/10ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/10ps
RUN_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
